// File: logic/ooo_pkg.sv
package ooo_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    // Architectural registers
    localparam int num_regs = 8;
    localparam int reg_bits = 3;

    // Destination tags in flight
    localparam int num_tags = 8;
    localparam int tag_bits = 3;

    // Reservation station slots
    localparam int rs_entries = 4;
    localparam int rs_bits = 2;

    // Cycles from ALU start to CDB for MUL
    localparam int mul_latency = 4;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_xor,
        op_mul
    } alu_op_e;

    typedef struct packed {
        alu_op_e               op;
        logic [reg_bits-1:0]   rd;
        logic [reg_bits-1:0]   rs1;
        logic [reg_bits-1:0]   rs2;
    } inst_t;

    // Tag view of an operand word that is still waiting
    typedef struct packed {
        logic [31-tag_bits:0]  pad;
        logic [tag_bits-1:0]   tag;
    } pending_t;

    // Data or tag, chosen by the ready bit next to it
    typedef union packed {
        logic [31:0]           value;
        pending_t              pending;
    } operand_u;

    typedef struct packed {
        logic                  ready;
        operand_u              word;
    } operand_t;

    typedef struct packed {
        alu_op_e               op;
        logic [reg_bits-1:0]   rd;
        logic [tag_bits-1:0]   dest_tag;
        operand_t              opa;
        operand_t              opb;
    } rs_load_t;

    typedef struct packed {
        alu_op_e               op;
        logic [reg_bits-1:0]   rd;
        logic [tag_bits-1:0]   dest_tag;
        logic [31:0]           a;
        logic [31:0]           b;
    } alu_req_t;

    typedef struct packed {
        logic                  valid;
        logic [tag_bits-1:0]   tag;
        logic [reg_bits-1:0]   rd;
        logic [31:0]           value;
    } cdb_t;

endpackage

// File: logic/dispatch_unit.sv
`timescale 1ns/1ps

module dispatch_unit (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          issue_valid,
    input  ooo_pkg::inst_t                issue_inst,
    output logic                          issue_stall,
    input  logic                          rs_full,
    output logic                          load_valid,
    output ooo_pkg::rs_load_t             load,
    input  ooo_pkg::cdb_t                 cdb,
    input  logic [ooo_pkg::reg_bits-1:0]  arch_index,
    output logic [31:0]                   arch_value
);
    import ooo_pkg::*;

    // Architectural state and register status table
    logic [31:0]          regs [num_regs];
    logic [num_regs-1:0]  pending;
    logic [tag_bits-1:0]  pend_tag [num_regs];
    logic [num_tags-1:0]  tag_busy;

    logic [tag_bits-1:0]  free_tag;
    logic                 tag_avail;
    logic                 accept;
    logic                 cdb_write;

    // Register value, CDB bypass, or the tag to wait on
    function automatic operand_t lookup(input logic [reg_bits-1:0] r);
        operand_t opnd;
        opnd = '0;
        if (!pending[r]) begin
            opnd.ready = 1'b1;
            opnd.word.value = regs[r];
        end else if (cdb.valid && cdb.tag == pend_tag[r]) begin
            opnd.ready = 1'b1;
            opnd.word.value = cdb.value;
        end else begin
            opnd.ready = 1'b0;
            opnd.word.pending.tag = pend_tag[r];
        end
        return opnd;
    endfunction

    // Lowest free tag
    always_comb begin
        free_tag = '0;
        for (int t = num_tags - 1; t >= 0; t--) begin
            if (!tag_busy[t]) free_tag = tag_bits'(t);
        end
    end

    assign tag_avail   = ~&tag_busy;
    assign issue_stall = rs_full | ~tag_avail;
    assign accept      = issue_valid & ~issue_stall;
    assign load_valid  = accept;

    assign load.op       = issue_inst.op;
    assign load.rd       = issue_inst.rd;
    assign load.dest_tag = free_tag;
    assign load.opa      = lookup(issue_inst.rs1);
    assign load.opb      = lookup(issue_inst.rs2);

    // Only the youngest writer of rd may update the register
    assign cdb_write = cdb.valid && pending[cdb.rd] && pend_tag[cdb.rd] == cdb.tag;

    assign arch_value = regs[arch_index];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i]     <= 32'(i);
                pend_tag[i] <= '0;
            end
            pending  <= '0;
            tag_busy <= '0;
        end else begin
            if (cdb_write) begin
                regs[cdb.rd]    <= cdb.value;
                pending[cdb.rd] <= 1'b0;
            end
            if (cdb.valid) tag_busy[cdb.tag] <= 1'b0;
            // New issue wins over a same-cycle CDB clear of rd
            if (accept) begin
                pending[issue_inst.rd]  <= 1'b1;
                pend_tag[issue_inst.rd] <= free_tag;
                tag_busy[free_tag]      <= 1'b1;
            end
        end
    end

    // Results only come back for tags handed out here
    cdb_tag_busy: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> tag_busy[cdb.tag])
        else $error("CDB broadcast on free tag %0d", cdb.tag);

endmodule

// File: logic/rs_entry.sv
`timescale 1ns/1ps

module rs_entry (
    input  logic               clock,
    input  logic               reset,
    input  logic               load_en,
    input  ooo_pkg::rs_load_t  load,
    input  logic               free,
    input  ooo_pkg::cdb_t      cdb,
    output logic               busy,
    output logic               ready,
    output ooo_pkg::alu_req_t  req
);
    import ooo_pkg::*;

    rs_load_t  entry;
    logic      snoop_a;
    logic      snoop_b;

    // Capture a missing operand when its producer broadcasts
    assign snoop_a = busy && !entry.opa.ready && cdb.valid
                     && cdb.tag == entry.opa.word.pending.tag;
    assign snoop_b = busy && !entry.opb.ready && cdb.valid
                     && cdb.tag == entry.opb.word.pending.tag;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (load_en) begin
            busy <= 1'b1;
        end else if (free) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (load_en) begin
            entry <= load;
        end else begin
            if (snoop_a) begin
                entry.opa.ready      <= 1'b1;
                entry.opa.word.value <= cdb.value;
            end
            if (snoop_b) begin
                entry.opb.ready      <= 1'b1;
                entry.opb.word.value <= cdb.value;
            end
        end
    end

    assign ready = busy & entry.opa.ready & entry.opb.ready;

    assign req.op       = entry.op;
    assign req.rd       = entry.rd;
    assign req.dest_tag = entry.dest_tag;
    assign req.a        = entry.opa.word.value;
    assign req.b        = entry.opb.word.value;

    // Station steers loads to empty slots only
    load_when_free: assert property (@(posedge clock) disable iff (reset)
        load_en |-> !busy)
        else $error("Load into occupied RS slot");

endmodule

// File: logic/reservation_station.sv
`timescale 1ns/1ps

module reservation_station (
    input  logic               clock,
    input  logic               reset,
    input  logic               load_valid,
    input  ooo_pkg::rs_load_t  load,
    output logic               rs_full,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               alu_ready,
    output logic               req_valid,
    output ooo_pkg::alu_req_t  req
);
    import ooo_pkg::*;

    logic [rs_entries-1:0]  slot_busy;
    logic [rs_entries-1:0]  slot_ready;
    logic [rs_entries-1:0]  slot_load;
    logic [rs_entries-1:0]  slot_free;
    alu_req_t               slot_req [rs_entries];

    logic [rs_bits-1:0]     load_idx;
    logic [rs_bits-1:0]     send_idx;
    logic                   any_ready;

    ////////////////////////////////////////////////////////////
    // Slots
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < rs_entries; g++) begin : slots
        rs_entry entry_i (
            .clock   (clock),
            .reset   (reset),
            .load_en (slot_load[g]),
            .load    (load),
            .free    (slot_free[g]),
            .cdb     (cdb),
            .busy    (slot_busy[g]),
            .ready   (slot_ready[g]),
            .req     (slot_req[g])
        );
    end

    ////////////////////////////////////////////////////////////
    // Allocation and select
    ////////////////////////////////////////////////////////////

    // Lowest free slot and lowest ready slot
    always_comb begin
        load_idx = '0;
        send_idx = '0;
        for (int i = rs_entries - 1; i >= 0; i--) begin
            if (!slot_busy[i]) load_idx = rs_bits'(i);
            if (slot_ready[i]) send_idx = rs_bits'(i);
        end
    end

    assign any_ready = |slot_ready;
    assign rs_full   = &slot_busy;
    assign req_valid = alu_ready & any_ready;
    assign req       = slot_req[send_idx];

    // One-hot load and free strobes
    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            slot_load[i] = load_valid && load_idx == rs_bits'(i);
            slot_free[i] = req_valid && send_idx == rs_bits'(i);
        end
    end

    // Dispatch stalls on a full station
    no_load_when_full: assert property (@(posedge clock) disable iff (reset)
        load_valid |-> !rs_full)
        else $error("Load while reservation station full");

endmodule

// File: logic/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               req_valid,
    input  ooo_pkg::alu_req_t  req,
    output logic               alu_ready,
    output ooo_pkg::cdb_t      cdb
);
    import ooo_pkg::*;

    typedef logic [$clog2(mul_latency):0] count_t;

    logic                 start;
    logic                 start_mul;
    logic                 mul_done;
    logic [31:0]          result;
    count_t               count;

    // MUL result waiting for its countdown
    logic [tag_bits-1:0]  mul_tag;
    logic [reg_bits-1:0]  mul_rd;
    logic [31:0]          mul_value;

    // CDB register
    logic                 res_valid;
    logic [tag_bits-1:0]  res_tag;
    logic [reg_bits-1:0]  res_rd;
    logic [31:0]          res_value;

    assign start     = req_valid & alu_ready;
    assign start_mul = start && req.op == op_mul;
    assign mul_done  = count == count_t'(1);
    assign alu_ready = count == '0;

    always_comb begin
        case (req.op)
            op_add:  result = req.a + req.b;
            op_sub:  result = req.a - req.b;
            op_xor:  result = req.a ^ req.b;
            default: result = req.a * req.b;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count     <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= (start && !start_mul) || mul_done;
            if (start_mul) count <= count_t'(mul_latency - 1);
            else if (count != '0) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (start_mul) begin
            mul_tag   <= req.dest_tag;
            mul_rd    <= req.rd;
            mul_value <= result;
        end
        if (start && !start_mul) begin
            res_tag   <= req.dest_tag;
            res_rd    <= req.rd;
            res_value <= result;
        end else if (mul_done) begin
            res_tag   <= mul_tag;
            res_rd    <= mul_rd;
            res_value <= mul_value;
        end
    end

    assign cdb = '{valid: res_valid, tag: res_tag, rd: res_rd, value: res_value};

    // Each result is broadcast once
    cdb_one_cycle: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |=> !(cdb.valid && cdb.tag == $past(cdb.tag)))
        else $error("CDB tag %0d held for more than one cycle", cdb.tag);

endmodule

// File: logic/ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          issue_valid,
    input  ooo_pkg::inst_t                issue_inst,
    output logic                          issue_stall,
    input  logic [ooo_pkg::reg_bits-1:0]  arch_index,
    output logic [31:0]                   arch_value,
    output ooo_pkg::cdb_t                 cdb
);
    import ooo_pkg::*;

    // Dispatch to station
    logic      load_valid;
    rs_load_t  load;
    logic      rs_full;

    // Station to ALU
    logic      req_valid;
    alu_req_t  req;
    logic      alu_ready;

    dispatch_unit dispatch_i (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_inst  (issue_inst),
        .issue_stall (issue_stall),
        .rs_full     (rs_full),
        .load_valid  (load_valid),
        .load        (load),
        .cdb         (cdb),
        .arch_index  (arch_index),
        .arch_value  (arch_value)
    );

    reservation_station station_i (
        .clock      (clock),
        .reset      (reset),
        .load_valid (load_valid),
        .load       (load),
        .rs_full    (rs_full),
        .cdb        (cdb),
        .alu_ready  (alu_ready),
        .req_valid  (req_valid),
        .req        (req)
    );

    alu_unit alu_i (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .alu_ready (alu_ready),
        .cdb       (cdb)
    );

endmodule

// File: dv/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int num_insts  = 400;
    localparam int max_cycles = num_insts * (mul_latency + 2) + 100;

    // One result the model expects to see on the CDB
    typedef struct packed {
        logic [tag_bits-1:0]  tag;
        logic [reg_bits-1:0]  rd;
        logic [31:0]          value;
    } outstanding_t;

    logic                 clock;
    logic                 reset;
    logic                 issue_valid;
    inst_t                issue_inst;
    logic                 issue_stall;
    logic [reg_bits-1:0]  arch_index;
    logic [31:0]          arch_value;
    cdb_t                 cdb;

    logic [31:0]   rng_state;
    logic [31:0]   model_regs [num_regs];
    outstanding_t  outstanding [$];
    int            errors = 0;
    int            accepted = 0;
    int            results = 0;
    int            stall_cycles = 0;
    int            cycle_count = 0;

    // Tag pool as dispatch sees it
    logic [num_tags-1:0]  model_tag_busy;
    logic                 release_valid;
    logic [tag_bits-1:0]  release_tag;

    ooo_core_top dut_i (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_inst  (issue_inst),
        .issue_stall (issue_stall),
        .arch_index  (arch_index),
        .arch_value  (arch_value),
        .cdb         (cdb)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout after %0d cycles, %0d results still outstanding",
                     cycle_count, outstanding.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic inst_t make_inst(input alu_op_e op, input logic [reg_bits-1:0] rd,
                                        input logic [reg_bits-1:0] rs1,
                                        input logic [reg_bits-1:0] rs2);
        inst_t inst;
        inst.op  = op;
        inst.rd  = rd;
        inst.rs1 = rs1;
        inst.rs2 = rs2;
        return inst;
    endfunction

    function automatic inst_t random_inst();
        logic [31:0] r;
        r = next_rand();
        return make_inst(alu_op_e'(r[31:30]), r[29:27], r[26:24], r[23:21]);
    endfunction

    // 32-bit wrapping arithmetic, MUL keeps the low half
    function automatic logic [31:0] model_result(input alu_op_e op, input logic [31:0] a,
                                                 input logic [31:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_xor:  return a ^ b;
            default: return a * b;
        endcase
    endfunction

    function automatic int lowest_free_tag();
        for (int t = 0; t < num_tags; t++) begin
            if (!model_tag_busy[t]) return t;
        end
        return -1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
            errors++;
        end
    endtask

    // Program-order execution on the model registers
    task automatic model_execute(input inst_t inst);
        outstanding_t entry;
        int tag;
        tag = lowest_free_tag();
        if (tag < 0) begin
            $display("Error at %0t: instruction accepted while every tag is in flight", $time);
            errors++;
            tag = 0;
        end
        entry.tag   = tag_bits'(tag);
        entry.rd    = inst.rd;
        entry.value = model_result(inst.op, model_regs[inst.rs1], model_regs[inst.rs2]);
        model_regs[inst.rd] = entry.value;
        model_tag_busy[entry.tag] = 1'b1;
        outstanding.push_back(entry);
        accepted++;
    endtask

    // A broadcast tag returns to the pool at the next rising edge
    task automatic observe_cdb();
        int hit;
        hit = -1;
        if (release_valid) model_tag_busy[release_tag] = 1'b0;
        release_valid = cdb.valid;
        release_tag   = cdb.tag;
        if (cdb.valid) begin
            results++;
            for (int i = 0; i < outstanding.size(); i++) begin
                if (outstanding[i].tag == cdb.tag) hit = i;
            end
            if (hit >= 0) begin
                check_value("cdb.rd", 32'(cdb.rd), 32'(outstanding[hit].rd));
                check_value("cdb.value", cdb.value, outstanding[hit].value);
                outstanding.delete(hit);
            end else begin
                $display("Error at %0t: CDB tag %0d (r%0d = %0h) belongs to no instruction",
                         $time, cdb.tag, cdb.rd, cdb.value);
                errors++;
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clock);
        observe_cdb();
    endtask

    task automatic issue_one(input inst_t inst);
        issue_valid = 1'b1;
        issue_inst  = inst;
        // Hold until dispatch can take it
        while (issue_stall) begin
            stall_cycles++;
            next_cycle();
        end
        model_execute(inst);
        next_cycle();
        issue_valid = 1'b0;
    endtask

    task automatic idle_cycle();
        issue_valid = 1'b0;
        next_cycle();
    endtask

    ////////////////////////////////////////////////////////////
    // Test phases
    ////////////////////////////////////////////////////////////

    task automatic run_chain();
        // MUL with dependents behind it, then independent ADDs
        issue_one(make_inst(op_mul, 3'd1, 3'd2, 3'd3));
        issue_one(make_inst(op_add, 3'd4, 3'd1, 3'd1));
        issue_one(make_inst(op_sub, 3'd5, 3'd4, 3'd2));
        issue_one(make_inst(op_add, 3'd6, 3'd6, 3'd7));
        issue_one(make_inst(op_add, 3'd7, 3'd7, 3'd0));
        // MUL into MUL, then a younger writer of r2 that finishes early
        issue_one(make_inst(op_mul, 3'd2, 3'd1, 3'd5));
        issue_one(make_inst(op_mul, 3'd3, 3'd2, 3'd2));
        issue_one(make_inst(op_xor, 3'd0, 3'd3, 3'd4));
        issue_one(make_inst(op_add, 3'd2, 3'd6, 3'd7));
    endtask

    task automatic run_mul_burst();
        stall_cycles = 0;
        for (int i = 0; i < 10; i++) begin
            issue_one(make_inst(op_mul, reg_bits'(i), reg_bits'(i + 1), reg_bits'(i + 3)));
        end
        if (stall_cycles == 0) begin
            $display("Error at %0t: issue_stall never rose during the MUL burst", $time);
            errors++;
        end
    endtask

    task automatic run_random();
        while (accepted < num_insts) begin
            if ((next_rand() >> 16) % 100 < 70) issue_one(random_inst());
            else idle_cycle();
        end
    endtask

    task automatic drain();
        while (outstanding.size() != 0) next_cycle();
        // Quiet window to catch a duplicated broadcast
        repeat (2 * mul_latency) next_cycle();
        check_value("cdb result count", 32'(results), 32'(accepted));
        check_value("outstanding entries", 32'(outstanding.size()), 32'd0);
    endtask

    task automatic check_arch();
        for (int i = 0; i < num_regs; i++) begin
            arch_index = reg_bits'(i);
            next_cycle();
            check_value($sformatf("arch_value[%0d]", i), arch_value, model_regs[i]);
        end
    endtask

    initial begin
        rng_state      = 32'h6bae_5e31;
        reset          = 1'b1;
        issue_valid    = 1'b0;
        issue_inst     = '0;
        arch_index     = '0;
        model_tag_busy = '0;
        release_valid  = 1'b0;
        release_tag    = '0;
        for (int i = 0; i < num_regs; i++) model_regs[i] = 32'(i);

        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_value("issue_stall", 32'(issue_stall), 32'd0);
        check_value("cdb.valid", 32'(cdb.valid), 32'd0);

        run_chain();
        run_mul_burst();
        run_random();
        drain();
        check_arch();

        $display("Errors: %0d, CDB results %0d of %0d instructions", errors, results, accepted);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
logic/ooo_pkg.sv
logic/dispatch_unit.sv
logic/rs_entry.sv
logic/reservation_station.sv
logic/alu_unit.sv
logic/ooo_core_top.sv
dv/ooo_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ooo_core_tb \
    -f build.f --Mdir obj_dir -o ooo_core_sim

out=$(./obj_dir/ooo_core_sim)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
